//--- hdl/axis_deserializer.sv
`timescale 1ns/1ps

module axis_deserializer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rx_valid,
    output logic                     rx_ready,
    input  noc_shim_pkg::flit_t      rx_flit,
    output logic                     out_valid,
    input  logic                     out_ready,
    output noc_shim_pkg::axis_word_t out_word
);

    import noc_shim_pkg::*;

    axis_word_t word_q;
    ser_index_t rx_index;
    logic       last_slice;
    logic       flit_take;

    assign last_slice = (rx_index == ser_index_t'(SER_FACTOR - 1));
    assign flit_take  = rx_valid && rx_ready;

    // Hold off while a finished word waits, unless it leaves now
    assign rx_ready = !out_valid || out_ready;
    assign out_word = word_q;

    always_ff @(posedge clk) begin
        if (flit_take) begin
            word_q.data[rx_index * FLIT_WIDTH +: FLIT_WIDTH] <= rx_flit.data;
            // Fourth flit carries the word's dest and last
            if (last_slice) begin
                word_q.dest <= rx_flit.dest;
                word_q.last <= rx_flit.tail;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_index  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (flit_take) begin
                rx_index <= last_slice ? '0 : rx_index + 1'b1;
            end
            if (flit_take && last_slice) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    a_word_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_word))
        else $error("output word changed while stalled");

endmodule : axis_deserializer

//--- hdl/axis_serializer.sv
`timescale 1ns/1ps

module axis_serializer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  noc_shim_pkg::axis_word_t in_word,
    output logic                     ser_valid,
    input  logic                     ser_ready,
    output noc_shim_pkg::flit_t      ser_flit
);

    import noc_shim_pkg::*;

    axis_word_t word_q;
    ser_index_t ser_index;
    logic       last_slice;
    logic       flit_take;
    logic       word_take;

    assign last_slice = (ser_index == ser_index_t'(SER_FACTOR - 1));
    assign flit_take  = ser_valid && ser_ready;
    assign word_take  = in_valid && in_ready;

    // Next word may enter on the edge that takes the final flit
    assign in_ready = !ser_valid || (ser_ready && last_slice);

    // Lowest slice goes out first
    assign ser_flit.data = word_q.data[ser_index * FLIT_WIDTH +: FLIT_WIDTH];
    assign ser_flit.dest = word_q.dest;
    assign ser_flit.tail = word_q.last && last_slice;

    always_ff @(posedge clk) begin
        if (word_take) begin
            word_q <= in_word;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ser_index <= '0;
            ser_valid <= 1'b0;
        end else begin
            if (flit_take) begin
                ser_index <= last_slice ? '0 : ser_index + 1'b1;
            end
            if (word_take) begin
                ser_valid <= 1'b1;
            end else if (flit_take && last_slice) begin
                ser_valid <= 1'b0;
            end
        end
    end

    a_flit_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ser_valid && !ser_ready |=> ser_valid && $stable(ser_flit))
        else $error("serializer flit changed while stalled");

endmodule : axis_serializer

//--- hdl/flit_rx.sv
`timescale 1ns/1ps

module flit_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  noc_shim_pkg::flit_t link_in,
    input  logic                link_recv,
    output logic                rx_valid,
    input  logic                rx_ready,
    output noc_shim_pkg::flit_t rx_flit,
    output logic                link_credit_ret
);

    import noc_shim_pkg::*;

    logic fifo_empty;
    logic fifo_full;
    logic fifo_rd;

    assign rx_valid = !fifo_empty;
    assign fifo_rd  = rx_valid && rx_ready;

    // One credit back per flit that leaves the buffer
    assign link_credit_ret = fifo_rd;

    // Depth equals the credit pool so a well-behaved sender never overruns it
    shim_fifo #(
        .WIDTH ($bits(flit_t)),
        .DEPTH (FLIT_CREDITS)
    ) rx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (link_recv),
        .wr_data (link_in),
        .rd_en   (fifo_rd),
        .rd_data (rx_flit),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    a_sender_credit: assert property (@(posedge clk) disable iff (!rst_n)
        link_recv |-> !fifo_full)
        else $error("link sender exceeded its credits");

endmodule : flit_rx

//--- hdl/flit_tx.sv
`timescale 1ns/1ps

module flit_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ser_valid,
    output logic                ser_ready,
    input  noc_shim_pkg::flit_t ser_flit,
    output noc_shim_pkg::flit_t link_out,
    output logic                link_send,
    input  logic                link_credit
);

    import noc_shim_pkg::*;

    flit_t         fifo_head;
    logic          fifo_empty;
    logic          fifo_full;
    logic          fifo_rd;
    credit_count_t credit_count;

    assign ser_ready = !fifo_full;

    // Pull a flit only while the far end has room
    assign fifo_rd = (credit_count != '0) && !fifo_empty;

    shim_fifo #(
        .WIDTH ($bits(flit_t)),
        .DEPTH (TX_WORD_DEPTH)
    ) tx_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (ser_valid && ser_ready),
        .wr_data (ser_flit),
        .rd_en   (fifo_rd),
        .rd_data (fifo_head),
        .empty   (fifo_empty),
        .full    (fifo_full)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_count <= credit_count_t'(FLIT_CREDITS);
            link_send    <= 1'b0;
        end else begin
            link_send <= fifo_rd;
            case ({link_credit, fifo_rd})
                2'b10:   credit_count <= credit_count + 1'b1;
                2'b01:   credit_count <= credit_count - 1'b1;
                default: credit_count <= credit_count;
            endcase
        end
    end

    // Send follows the read by one cycle
    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            link_out <= fifo_head;
        end
    end

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_count <= FLIT_CREDITS)
        else $error("credit count above the pool size");

endmodule : flit_tx

//--- hdl/noc_shim.sv
`timescale 1ns/1ps

module noc_shim (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  noc_shim_pkg::axis_word_t in_word,
    output noc_shim_pkg::flit_t      link_out,
    output logic                     link_send,
    input  logic                     link_credit,
    input  noc_shim_pkg::flit_t      link_in,
    input  logic                     link_recv,
    output logic                     link_credit_ret,
    output logic                     out_valid,
    input  logic                     out_ready,
    output noc_shim_pkg::axis_word_t out_word
);

    import noc_shim_pkg::*;

    logic  ser_valid;
    logic  ser_ready;
    flit_t ser_flit;
    logic  rx_valid;
    logic  rx_ready;
    flit_t rx_flit;

    // Ingress path
    axis_serializer serializer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_word   (in_word),
        .ser_valid (ser_valid),
        .ser_ready (ser_ready),
        .ser_flit  (ser_flit)
    );

    flit_tx flit_tx_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ser_valid   (ser_valid),
        .ser_ready   (ser_ready),
        .ser_flit    (ser_flit),
        .link_out    (link_out),
        .link_send   (link_send),
        .link_credit (link_credit)
    );

    // Egress path
    flit_rx flit_rx_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .link_in         (link_in),
        .link_recv       (link_recv),
        .rx_valid        (rx_valid),
        .rx_ready        (rx_ready),
        .rx_flit         (rx_flit),
        .link_credit_ret (link_credit_ret)
    );

    axis_deserializer deserializer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_valid  (rx_valid),
        .rx_ready  (rx_ready),
        .rx_flit   (rx_flit),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word)
    );

endmodule : noc_shim

//--- hdl/noc_shim_pkg.sv
package noc_shim_pkg;

    // AXI-stream beat and flit geometry
    localparam int WORD_WIDTH = 64;
    localparam int SER_FACTOR = 4;
    localparam int FLIT_WIDTH = WORD_WIDTH / SER_FACTOR;
    localparam int DEST_WIDTH = 3;

    // Link credit pool, equal to the receive buffer depth
    localparam int FLIT_CREDITS = 4;
    localparam int TX_WORD_DEPTH = 4;

    typedef struct packed {
        logic [WORD_WIDTH - 1:0] data;
        logic [DEST_WIDTH - 1:0] dest;
        logic                    last;
    } axis_word_t;

    // Tail is set only on the final flit of a packet's last word
    typedef struct packed {
        logic [FLIT_WIDTH - 1:0] data;
        logic [DEST_WIDTH - 1:0] dest;
        logic                    tail;
    } flit_t;

    typedef logic [$clog2(FLIT_CREDITS + 1) - 1:0] credit_count_t;

    typedef logic [$clog2(SER_FACTOR) - 1:0] ser_index_t;

endpackage : noc_shim_pkg

//--- hdl/shim_fifo.sv
`timescale 1ns/1ps

module shim_fifo #(
    parameter int WIDTH = 20,
    parameter int DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic [WIDTH - 1:0] wr_data,
    input  logic               rd_en,
    output logic [WIDTH - 1:0] rd_data,
    output logic               empty,
    output logic               full
);

    logic [WIDTH - 1:0]             mem [DEPTH];
    logic [$clog2(DEPTH) - 1:0]     wr_ptr;
    logic [$clog2(DEPTH) - 1:0]     rd_ptr;
    logic [$clog2(DEPTH + 1) - 1:0] count;

    // Head entry is always visible
    assign rd_data = mem[rd_ptr];
    assign empty   = (count == '0);
    assign full    = (count == DEPTH);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Users must respect full and empty
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> !full)
        else $error("shim_fifo write while full");
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> !empty)
        else $error("shim_fifo read while empty");

endmodule : shim_fifo

//--- noc_shim.f
hdl/noc_shim_pkg.sv
hdl/shim_fifo.sv
hdl/axis_serializer.sv
hdl/flit_tx.sv
hdl/flit_rx.sv
hdl/axis_deserializer.sv
hdl/noc_shim.sv
test/noc_shim_tb.sv

//--- test/noc_shim_tb.sv
`timescale 1ns/1ps

module noc_shim_tb;

    import noc_shim_pkg::*;

    // Words sent across all tests, worst case
    localparam int TOTAL_WORDS    = 27;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_WORDS + 200;

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    logic       in_ready;
    axis_word_t in_word;
    flit_t      link_out;
    logic       link_send;
    logic       link_credit;
    flit_t      link_in;
    logic       link_recv;
    logic       link_credit_ret;
    logic       out_valid;
    logic       out_ready;
    axis_word_t out_word;

    logic        credit_loop_en;
    logic        manual_credit;
    flit_t       exp_flits[$];
    axis_word_t  exp_words[$];
    flit_t       exp_flit;
    axis_word_t  exp_word;
    int          errors      = 0;
    int          send_count  = 0;
    int          tail_count  = 0;
    int          out_count   = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state   = 32'h4a5c;

    noc_shim noc_shim_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_word         (in_word),
        .link_out        (link_out),
        .link_send       (link_send),
        .link_credit     (link_credit),
        .link_in         (link_in),
        .link_recv       (link_recv),
        .link_credit_ret (link_credit_ret),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_word        (out_word)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // Link wire between the two ends, with optional credit cut
    task automatic run_link_model();
        forever begin
            @(posedge clk);
            link_in     <= link_out;
            link_recv   <= rst_n && link_send;
            link_credit <= rst_n && ((credit_loop_en && link_credit_ret) || manual_credit);
        end
    endtask

    initial run_link_model();

    always @(posedge clk) begin
        if (rst_n && link_send) begin
            send_count++;
            if (link_out.tail) begin
                tail_count++;
            end
            if (exp_flits.size() == 0) begin
                errors++;
                $display("Unexpected flit sent on the link at %0t", $time);
            end else begin
                exp_flit = exp_flits.pop_front();
                if (link_out !== exp_flit) begin
                    errors++;
                    $display("mismatch at %0t: flit expected %h/%0d/%0b, got %h/%0d/%0b",
                             $time, exp_flit.data, exp_flit.dest, exp_flit.tail,
                             link_out.data, link_out.dest, link_out.tail);
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            out_count++;
            if (exp_words.size() == 0) begin
                errors++;
                $display("Unexpected output word at %0t", $time);
            end else begin
                exp_word = exp_words.pop_front();
                if (out_word !== exp_word) begin
                    errors++;
                    $display("mismatch at %0t: word expected %h/%0d/%0b, got %h/%0d/%0b",
                             $time, exp_word.data, exp_word.dest, exp_word.last,
                             out_word.data, out_word.dest, out_word.last);
                end
            end
        end
    end

    task automatic expect_equal(input string what, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("mismatch at %0t: %s expected %0d got %0d", $time, what, expected, actual);
        end
    endtask

    // Expected flits follow the slicing rule, lowest slice first
    task automatic send_word(input axis_word_t w);
        int    k;
        flit_t f;
        for (k = 0; k < SER_FACTOR; k++) begin
            f.data = w.data[k * FLIT_WIDTH +: FLIT_WIDTH];
            f.dest = w.dest;
            f.tail = w.last && (k == SER_FACTOR - 1);
            exp_flits.push_back(f);
        end
        exp_words.push_back(w);
        @(posedge clk);
        in_valid <= 1'b1;
        in_word  <= w;
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic random_word(output axis_word_t w, input logic [DEST_WIDTH - 1:0] dest,
                               input logic last);
        w.data = {next_random(), next_random()};
        w.dest = dest;
        w.last = last;
    endtask

    task automatic wait_drain();
        while (exp_words.size() != 0 || exp_flits.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic pulse_credit();
        @(posedge clk);
        manual_credit <= 1'b1;
        @(posedge clk);
        manual_credit <= 1'b0;
    endtask

    task automatic reset_state_test();
        @(negedge clk);
        if (link_send !== 1'b0 || link_credit_ret !== 1'b0 || out_valid !== 1'b0
                || in_ready !== 1'b1) begin
            errors++;
            $display("mismatch at %0t: reset state send %b ret %b out_valid %b in_ready %b",
                     $time, link_send, link_credit_ret, out_valid, in_ready);
        end
    endtask

    task automatic single_word_test();
        axis_word_t w;
        int         base_send;
        int         base_tail;
        base_send = send_count;
        base_tail = tail_count;
        w.data = 64'hd00d_c0de_beef_1234;
        w.dest = 3'd5;
        w.last = 1'b1;
        send_word(w);
        wait_drain();
        expect_equal("single word sends", SER_FACTOR, send_count - base_send);
        expect_equal("single word tails", 1, tail_count - base_tail);
    endtask

    task automatic packet_test();
        axis_word_t            w;
        logic [DEST_WIDTH - 1:0] dest;
        int                    p;
        int                    n;
        int                    len;
        int                    base_tail;
        base_tail = tail_count;
        for (p = 0; p < 4; p++) begin
            len  = 1 + (next_random() % 5);
            dest = DEST_WIDTH'(next_random());
            for (n = 0; n < len; n++) begin
                random_word(w, dest, n == len - 1);
                send_word(w);
            end
        end
        wait_drain();
        expect_equal("packet tails", 4, tail_count - base_tail);
    endtask

    task automatic credit_limit_test();
        axis_word_t w;
        int         base;
        int         i;
        @(posedge clk);
        credit_loop_en <= 1'b0;
        base = send_count;
        for (i = 0; i < 2; i++) begin
            random_word(w, 3'(i + 2), 1'b1);
            send_word(w);
        end
        while (send_count - base < FLIT_CREDITS) begin
            @(negedge clk);
        end
        repeat (12) @(negedge clk);
        expect_equal("sends with no credit back", FLIT_CREDITS, send_count - base);
        for (i = 0; i < FLIT_CREDITS; i++) begin
            pulse_credit();
            repeat (8) @(negedge clk);
            expect_equal("sends after one credit", FLIT_CREDITS + i + 1, send_count - base);
        end
        wait_drain();
        // Give back the credits that the cut link swallowed
        for (i = 0; i < FLIT_CREDITS; i++) begin
            pulse_credit();
        end
        @(posedge clk);
        credit_loop_en <= 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic backpressure_test();
        axis_word_t w;
        int         base;
        int         i;
        @(posedge clk);
        out_ready <= 1'b0;
        base = out_count;
        // Enough words to fill deserializer, both FIFOs and the serializer
        for (i = 0; i < 4; i++) begin
            random_word(w, 3'(7 - i), i == 3);
            send_word(w);
        end
        repeat (30) @(negedge clk);
        // The first word waits at the output, intact
        if (out_valid !== 1'b1 || out_word !== exp_words[0]) begin
            errors++;
            $display("mismatch at %0t: held word expected %h valid 1, got %h valid %b",
                     $time, exp_words[0].data, out_word.data, out_valid);
        end
        if (in_ready !== 1'b0) begin
            errors++;
            $display("Input side still ready at %0t with the egress path stalled", $time);
        end
        @(posedge clk);
        out_ready <= 1'b1;
        wait_drain();
        expect_equal("words after release", 4, out_count - base);
    endtask

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_word        = '0;
        link_credit    = 1'b0;
        link_in        = '0;
        link_recv      = 1'b0;
        out_ready      = 1'b1;
        credit_loop_en = 1'b1;
        manual_credit  = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_state_test();
        single_word_test();
        packet_test();
        credit_limit_test();
        backpressure_test();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : noc_shim_tb
